// ==== verilog/gfx_consts.svh ====
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// object memory geometry
`define GFX_SLOTS   32
`define GFX_SLOT_W  5

`define GFX_COORD_W 16   // signed vertex coordinate

// rotation coefficients are stored times this value
`define GFX_ROT_DIV 100

`endif

// ==== verilog/gfx_obj_pkg.sv ====
`include "gfx_consts.svh"

package gfx_obj_pkg;

    typedef struct packed {
        logic signed [`GFX_COORD_W-1:0] x;
        logic signed [`GFX_COORD_W-1:0] y;
    } vertex_t;

    // number of used vertices is kind + 1
    typedef enum logic [1:0] {
        KIND_POINT = 2'd0,
        KIND_LINE  = 2'd1,
        KIND_TRI   = 2'd2,
        KIND_QUAD  = 2'd3
    } obj_kind_t;

    typedef struct packed {
        obj_kind_t     kind;
        logic [5:0]    rsvd;
        logic [7:0]    colour;
        vertex_t [3:0] v;        // v[0] in the low bits
    } obj_t;

    // one access to object memory
    typedef struct packed {
        logic                   wr;
        logic [`GFX_SLOT_W-1:0] slot;
        obj_t                   obj;
    } mem_req_t;

endpackage

// ==== verilog/gfx_cmd_pkg.sv ====
`include "gfx_consts.svh"

package gfx_cmd_pkg;

    typedef enum logic [3:0] {
        OP_CREATE    = 4'h0,
        OP_DELETE    = 4'h1,
        OP_TRANS_ONE = 4'h3,
        OP_TRANS_ALL = 4'h4,
        OP_SCALE     = 4'h5,
        OP_ROT_L     = 4'h6,
        OP_ROT_R     = 4'h7,
        OP_REF_X     = 4'h8,   // mirror about the x axis
        OP_REF_Y     = 4'h9,
        OP_REF_XY    = 4'hA,
        OP_LOADBACK  = 4'hF
    } gmt_op_t;

    typedef struct packed {
        logic [1:0] pt;     // point select for translate-one
        logic       app_y;
        logic       app_x;
    } code_pick_t;

    typedef struct packed {
        logic       rsvd;
        logic [2:0] step;   // scale step or rotation step
    } code_amt_t;

    typedef union packed {
        code_pick_t pick;
        code_amt_t  amt;
    } gmt_code_u;

    typedef struct packed {
        gmt_op_t                  op;
        gmt_code_u                code;
        logic [`GFX_SLOT_W-1:0]   slot;
        gfx_obj_pkg::obj_kind_t   kind;
        logic [7:0]               colour;
        gfx_obj_pkg::vertex_t [3:0] v;
    } gfx_cmd_t;

endpackage

// ==== verilog/coeff_rom.sv ====
`timescale 1ns/1ns

module coeff_rom (
    input  logic              clk,
    input  logic [3:0]        addr,   // {right, step}
    output logic signed [7:0] c11,
    output logic signed [7:0] c12,
    output logic signed [7:0] c21,
    output logic signed [7:0] c22
);

    logic signed [7:0] cos_v;
    logic signed [7:0] sin_v;

    // steps of 22.5 degrees, times 100 and rounded
    always_comb begin
        case (addr[2:0])
            3'd0:    {cos_v, sin_v} = {8'sd100, 8'sd0};
            3'd1:    {cos_v, sin_v} = {8'sd92, 8'sd38};
            3'd2:    {cos_v, sin_v} = {8'sd71, 8'sd71};
            3'd3:    {cos_v, sin_v} = {8'sd38, 8'sd92};
            3'd4:    {cos_v, sin_v} = {8'sd0, 8'sd100};    // exact quarter turn
            3'd5:    {cos_v, sin_v} = {-8'sd38, 8'sd92};
            3'd6:    {cos_v, sin_v} = {-8'sd71, 8'sd71};
            default: {cos_v, sin_v} = {-8'sd92, 8'sd38};
        endcase
    end

    // left turns counter-clockwise, right is the transpose
    always_ff @(posedge clk) begin
        c11 <= cos_v;
        c12 <= addr[3] ? sin_v : -sin_v;
        c21 <= addr[3] ? -sin_v : sin_v;
        c22 <= cos_v;
    end

endmodule

// ==== verilog/matrix_unit.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module matrix_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gfx_cmd_pkg::gfx_cmd_t  cmd,
    input  logic                   cmd_go,
    output logic                   busy,
    output logic                   cmd_done,
    output logic                   cmd_err,
    output logic [`GFX_SLOT_W-1:0] new_slot,
    output gfx_obj_pkg::obj_t      rd_obj,
    input  logic                   slot_full,
    input  logic [`GFX_SLOT_W-1:0] free_slot,
    input  logic [`GFX_SLOTS-1:0]  occupied,
    output logic                   alloc,
    output logic                   free,
    output gfx_obj_pkg::mem_req_t  m_req,
    output logic                   m_req_vld,
    input  gfx_obj_pkg::obj_t      m_rdata,
    input  logic                   m_rvld
);

    typedef enum logic [3:0] {
        S_IDLE, S_ALLOC, S_CWR, S_DEL, S_RD, S_WAIT,
        S_LOAD, S_CENT, S_MULT, S_WR, S_FIN
    } state_t;

    state_t                 state;
    gfx_cmd_pkg::gfx_cmd_t  cmd_r;
    gfx_obj_pkg::obj_kind_t kind_r;
    gfx_obj_pkg::obj_t      obj_new;
    gfx_obj_pkg::obj_t      obj_wb;
    logic [7:0]             colour_r;
    logic signed [15:0]     vx [4];
    logic signed [15:0]     vy [4];
    logic signed [7:0]      c11, c12, c21, c22;   // transform matrix
    logic signed [7:0]      d11, d12, d21, d22;   // divisor of each element
    logic signed [15:0]     ox, oy;               // offset or centroid, added last
    logic signed [7:0]      rc11, rc12, rc21, rc22;
    logic signed [7:0]      scl_num, scl_den;
    logic signed [17:0]     sum_x, sum_y;
    logic signed [15:0]     cx, cy;
    logic signed [3:0]      cnt;
    logic [3:0]             used, touch;
    logic                   occ, centred, fin, fin_err;

    coeff_rom rom_inst (
        .clk  (clk),
        .addr ({cmd_r.op == gfx_cmd_pkg::OP_ROT_R, cmd_r.code.amt.step}),
        .c11  (rc11),
        .c12  (rc12),
        .c21  (rc21),
        .c22  (rc22)
    );

    // a*ca/da + b*cb/db + off, each division truncates toward zero
    function automatic logic signed [15:0] mac(
        input logic signed [15:0] a,
        input logic signed [15:0] b,
        input logic signed [7:0]  ca,
        input logic signed [7:0]  da,
        input logic signed [7:0]  cb,
        input logic signed [7:0]  db,
        input logic signed [15:0] off
    );
        logic signed [31:0] pa;
        logic signed [31:0] pb;
        pa = a * ca;
        pb = b * cb;
        return 16'(pa / da + pb / db + off);
    endfunction

    assign busy = (state != S_IDLE);

    always_comb begin
        occ     = occupied[cmd_r.slot];
        centred = cmd_r.op inside {gfx_cmd_pkg::OP_SCALE, gfx_cmd_pkg::OP_ROT_L,
                                   gfx_cmd_pkg::OP_ROT_R, gfx_cmd_pkg::OP_REF_X,
                                   gfx_cmd_pkg::OP_REF_Y, gfx_cmd_pkg::OP_REF_XY};
        cnt     = 4'(kind_r) + 4'sd1;
        sum_x   = '0;
        sum_y   = '0;
        obj_wb.kind   = kind_r;
        obj_wb.rsvd   = '0;
        obj_wb.colour = colour_r;
        for (int i = 0; i < 4; i++) begin
            used[i]  = (i <= int'(kind_r));
            touch[i] = used[i] && (cmd_r.op != gfx_cmd_pkg::OP_TRANS_ONE ||
                                   int'(cmd_r.code.pick.pt) == i);
            if (used[i]) begin
                sum_x = sum_x + vx[i];
                sum_y = sum_y + vy[i];
            end
            obj_wb.v[i].x = vx[i];
            obj_wb.v[i].y = vy[i];
        end
        cx = 16'(sum_x / cnt);
        cy = 16'(sum_y / cnt);
        case (cmd_r.code.amt.step[1:0])   // 1/2, 3/4, 3/2, 2
            2'd0:    {scl_num, scl_den} = {8'sd1, 8'sd2};
            2'd1:    {scl_num, scl_den} = {8'sd3, 8'sd4};
            2'd2:    {scl_num, scl_den} = {8'sd3, 8'sd2};
            default: {scl_num, scl_den} = {8'sd2, 8'sd1};
        endcase
        obj_new.kind   = cmd_r.kind;
        obj_new.rsvd   = '0;
        obj_new.colour = cmd_r.colour;
        obj_new.v      = cmd_r.v;
        // refused create, or an empty slot touched
        fin_err   = (state == S_ALLOC && slot_full) || ((state == S_DEL || state == S_RD) && !occ);
        fin       = fin_err || state inside {S_CWR, S_DEL, S_WR, S_FIN};
        alloc     = (state == S_ALLOC) && !slot_full;
        free      = (state == S_DEL) && occ;
        m_req_vld = state inside {S_CWR, S_WR} || (state == S_RD && occ);
        m_req.wr   = state inside {S_CWR, S_WR};
        m_req.slot = (state == S_CWR) ? new_slot : cmd_r.slot;   // also the slot to free
        m_req.obj  = (state == S_CWR) ? obj_new : obj_wb;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            cmd_done <= 1'b0;
            cmd_err  <= 1'b0;
        end else begin
            cmd_done <= fin;
            cmd_err  <= fin_err;
            if (fin) begin
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: if (cmd_go) begin
                        case (cmd.op)
                            gfx_cmd_pkg::OP_CREATE: state <= S_ALLOC;
                            gfx_cmd_pkg::OP_DELETE: state <= S_DEL;
                            4'h2, 4'hB, 4'hC, 4'hD, 4'hE: state <= S_FIN;   // no-op
                            default: state <= S_RD;
                        endcase
                    end
                    S_ALLOC: state <= S_CWR;
                    S_RD:    state <= S_WAIT;
                    S_WAIT: if (m_rvld) begin
                        state <= (cmd_r.op == gfx_cmd_pkg::OP_LOADBACK) ? S_FIN : S_LOAD;
                    end
                    S_LOAD:  state <= centred ? S_CENT : S_MULT;
                    S_CENT:  state <= S_MULT;
                    S_MULT:  state <= S_WR;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_go)
            cmd_r <= cmd;
        if (alloc)
            new_slot <= free_slot;
        if (state == S_WAIT && m_rvld) begin
            kind_r   <= m_rdata.kind;
            colour_r <= m_rdata.colour;
            for (int i = 0; i < 4; i++) begin
                vx[i] <= m_rdata.v[i].x;
                vy[i] <= m_rdata.v[i].y;
            end
            if (cmd_r.op == gfx_cmd_pkg::OP_LOADBACK)
                rd_obj <= m_rdata;
        end
        if (state == S_LOAD) begin
            // identity first, the op overrides what it needs
            {c11, c12, c21, c22} <= {8'sd1, 8'sd0, 8'sd0, 8'sd1};
            {d11, d12, d21, d22} <= {8'sd1, 8'sd1, 8'sd1, 8'sd1};
            ox <= '0;
            oy <= '0;
            case (cmd_r.op)
                gfx_cmd_pkg::OP_TRANS_ONE, gfx_cmd_pkg::OP_TRANS_ALL: begin
                    if (cmd_r.code.pick.app_x)
                        ox <= cmd_r.v[0].x;
                    if (cmd_r.code.pick.app_y)
                        oy <= cmd_r.v[0].y;
                end
                gfx_cmd_pkg::OP_SCALE: begin
                    {c11, c22} <= {scl_num, scl_num};
                    {d11, d22} <= {scl_den, scl_den};
                end
                gfx_cmd_pkg::OP_ROT_L, gfx_cmd_pkg::OP_ROT_R: begin
                    {c11, c12, c21, c22} <= {rc11, rc12, rc21, rc22};
                    {d11, d12, d21, d22} <= {4{8'(`GFX_ROT_DIV)}};
                end
                gfx_cmd_pkg::OP_REF_X:  c22 <= -8'sd1;
                gfx_cmd_pkg::OP_REF_Y:  c11 <= -8'sd1;
                gfx_cmd_pkg::OP_REF_XY: {c11, c22} <= {-8'sd1, -8'sd1};
                default: ;
            endcase
        end
        if (state == S_CENT) begin
            ox <= cx;
            oy <= cy;
            for (int i = 0; i < 4; i++) begin
                if (used[i]) begin
                    vx[i] <= vx[i] - cx;
                    vy[i] <= vy[i] - cy;
                end
            end
        end
        if (state == S_MULT) begin
            for (int i = 0; i < 4; i++) begin
                if (touch[i]) begin
                    vx[i] <= mac(vx[i], vy[i], c11, d11, c12, d12, ox);
                    vy[i] <= mac(vx[i], vy[i], c21, d21, c22, d22, oy);
                end
            end
        end
    end

endmodule

// ==== verilog/obj_slot_table.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module obj_slot_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  logic                   free,
    input  logic [`GFX_SLOT_W-1:0] free_idx,
    output logic                   full,
    output logic [`GFX_SLOT_W-1:0] free_slot,
    output logic [`GFX_SLOTS-1:0]  occupied
);

    // lowest clear bit wins
    always_comb begin
        full      = &occupied;
        free_slot = '0;
        for (int i = `GFX_SLOTS - 1; i >= 0; i--) begin
            if (!occupied[i])
                free_slot = i[`GFX_SLOT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;   // table starts empty
        end else begin
            if (alloc && !full)
                occupied[free_slot] <= 1'b1;
            if (free)
                occupied[free_idx] <= 1'b0;
        end
    end

endmodule

// ==== verilog/obj_mem_arb.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module obj_mem_arb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  gfx_obj_pkg::mem_req_t m_req,
    input  logic                  m_req_vld,
    input  gfx_obj_pkg::mem_req_t d_req,
    input  logic                  d_req_vld,
    output logic                  m_grant,
    output logic                  d_grant,
    output logic                  m_rvld,
    output logic                  d_rvld,
    output gfx_obj_pkg::obj_t     rdata
);

    gfx_obj_pkg::obj_t     mem [`GFX_SLOTS];
    gfx_obj_pkg::mem_req_t req;   // winner of this cycle

    // matrix side always wins, display retries
    assign m_grant = m_req_vld;
    assign d_grant = d_req_vld && !m_req_vld;
    assign req     = m_grant ? m_req : d_req;

    always_ff @(posedge clk) begin
        if (m_grant || d_grant) begin
            if (req.wr)
                mem[req.slot] <= req.obj;
            else
                rdata <= mem[req.slot];
        end
    end

    // read data lands one cycle after the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_rvld <= 1'b0;
            d_rvld <= 1'b0;
        end else begin
            m_rvld <= m_grant && !m_req.wr;
            d_rvld <= d_grant && !d_req.wr;
        end
    end

endmodule

// ==== verilog/display_fetch.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module display_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame,
    input  logic [`GFX_SLOTS-1:0]  occupied,
    output gfx_obj_pkg::mem_req_t  d_req,
    output logic                   d_req_vld,
    input  logic                   d_grant,
    input  logic                   d_rvld,
    input  gfx_obj_pkg::obj_t      rdata,
    output gfx_obj_pkg::obj_t      disp_obj,
    output logic                   disp_vld,
    output logic                   disp_end
);

    logic                   scan;
    logic                   step;
    logic [`GFX_SLOT_W-1:0] idx;
    logic [1:0]             tail;   // holds disp_end behind the last read

    // empty slots are skipped, occupied ones wait for the grant
    assign d_req_vld = scan && occupied[idx];
    assign step      = scan && (!occupied[idx] || d_grant);

    always_comb begin
        d_req      = '0;   // reads only
        d_req.slot = idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan     <= 1'b0;
            idx      <= '0;
            tail     <= '0;
            disp_vld <= 1'b0;
            disp_end <= 1'b0;
        end else begin
            disp_vld <= d_rvld;
            disp_end <= tail[1];
            tail     <= {tail[0], step && (&idx)};
            if (frame && !scan && tail == 2'b00) begin
                scan <= 1'b1;   // frame ignored mid-scan
                idx  <= '0;
            end else if (step) begin
                idx <= idx + 1'b1;
                if (&idx)
                    scan <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d_rvld)
            disp_obj <= rdata;
    end

endmodule

// ==== verilog/gfx_engine.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module gfx_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gfx_cmd_pkg::gfx_cmd_t  cmd,
    input  logic                   cmd_go,
    output logic                   busy,
    output logic                   cmd_done,
    output logic                   cmd_err,
    output logic [`GFX_SLOT_W-1:0] new_slot,
    output gfx_obj_pkg::obj_t      rd_obj,
    input  logic                   frame,
    output gfx_obj_pkg::obj_t      disp_obj,
    output logic                   disp_vld,
    output logic                   disp_end
);

    logic                   slot_full;
    logic [`GFX_SLOT_W-1:0] free_slot;
    logic [`GFX_SLOTS-1:0]  occupied;
    logic                   alloc;
    logic                   free;
    gfx_obj_pkg::mem_req_t  m_req;
    gfx_obj_pkg::mem_req_t  d_req;
    logic                   m_req_vld, d_req_vld;
    logic                   m_grant, d_grant;
    logic                   m_rvld, d_rvld;
    gfx_obj_pkg::obj_t      rdata;   // shared read bus

    matrix_unit matrix_unit_inst (.m_rdata(rdata), .*);

    // a delete frees the slot the matrix unit presents on its request
    obj_slot_table slot_table_inst (.full(slot_full), .free_idx(m_req.slot), .*);

    obj_mem_arb mem_arb_inst (.*);

    display_fetch display_fetch_inst (.*);

endmodule

// ==== verif/gfx_engine_assert.sv ====
`timescale 1ns/1ns

module gfx_engine_assert (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic cmd_done,
    input logic disp_vld,
    input logic disp_end,
    input logic m_req_vld,
    input logic d_req_vld,
    input logic m_grant,
    input logic d_grant
);

    int unsigned fail_cnt = 0;   // read by the testbench

    busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> cmd_done)
        else begin
            $error("busy fell without cmd_done");
            fail_cnt++;
        end

    done_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_done |-> !busy && $past(busy))
        else begin
            $error("cmd_done while busy, or without a command");
            fail_cnt++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_done |=> !cmd_done)
        else begin
            $error("cmd_done longer than one cycle");
            fail_cnt++;
        end

    // stream end is a beat of its own
    disp_vld_not_end: assert property (@(posedge clk) disable iff (!rst_n)
        !(disp_vld && disp_end))
        else begin
            $error("disp_vld and disp_end high together");
            fail_cnt++;
        end

    m_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        m_grant |-> m_req_vld)
        else begin
            $error("matrix grant without request");
            fail_cnt++;
        end

    d_grant_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        d_grant |-> d_req_vld)
        else begin
            $error("display grant without request");
            fail_cnt++;
        end

endmodule

// ==== verif/gfx_engine_tb.sv ====
`timescale 1ns/1ns
`include "gfx_consts.svh"

module gfx_engine_tb;

    localparam int clk_period      = 100;
    localparam int n_cmds          = 138;   // commands issued by the main sequence
    localparam int n_frames        = 2;
    localparam int watchdog_cycles = n_cmds * 40 + n_frames * 200 + 3;

    // rotation steps of 22.5 degrees, times 100 and rounded
    localparam int cos_tab [8]   = '{100, 92, 71, 38, 0, -38, -71, -92};
    localparam int sin_tab [8]   = '{0, 38, 71, 92, 100, 92, 71, 38};
    localparam int scale_num [4] = '{1, 3, 3, 2};
    localparam int scale_den [4] = '{2, 4, 2, 1};

    logic                   clk = 1'b0;
    logic                   rst_n;
    gfx_cmd_pkg::gfx_cmd_t  cmd;
    logic                   cmd_go;
    logic                   busy;
    logic                   cmd_done;
    logic                   cmd_err;
    logic [`GFX_SLOT_W-1:0] new_slot;
    gfx_obj_pkg::obj_t      rd_obj;
    logic                   frame;
    gfx_obj_pkg::obj_t      disp_obj;
    logic                   disp_vld;
    logic                   disp_end;

    gfx_obj_pkg::obj_t      model_obj [`GFX_SLOTS];
    logic [`GFX_SLOTS-1:0]  model_occ;
    logic [31:0]            lfsr_state = 32'h5245;

    gfx_engine gfx_engine_inst (.*);

    bind gfx_engine gfx_engine_assert assert_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    // nine fresh bits folded into -200..200
    function automatic logic signed [15:0] rand_coord();
        int v;
        v = 0;
        for (int i = 0; i < 9; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return 16'(v % 401 - 200);
    endfunction

    // reference for one geometry command on a stored object
    function automatic gfx_obj_pkg::obj_t expect_xform(
        input gfx_obj_pkg::obj_t     o,
        input gfx_cmd_pkg::gfx_cmd_t c
    );
        gfx_obj_pkg::obj_t r;
        int n, k, sx, sy, cx, cy, dx, dy;
        int m [4];   // c11 c12 c21 c22
        int d [4];
        r = o;
        r.rsvd = '0;
        n = int'(o.kind) + 1;
        k = int'(c.code.amt.step);
        m = '{1, 0, 0, 1};
        d = '{1, 1, 1, 1};
        if (c.op inside {gfx_cmd_pkg::OP_TRANS_ONE, gfx_cmd_pkg::OP_TRANS_ALL}) begin
            for (int i = 0; i < n; i++) begin
                if (c.op == gfx_cmd_pkg::OP_TRANS_ALL || int'(c.code.pick.pt) == i) begin
                    if (c.code.pick.app_x)
                        r.v[i].x = o.v[i].x + c.v[0].x;
                    if (c.code.pick.app_y)
                        r.v[i].y = o.v[i].y + c.v[0].y;
                end
            end
            return r;
        end
        case (c.op)
            gfx_cmd_pkg::OP_SCALE: begin
                m = '{scale_num[k % 4], 0, 0, scale_num[k % 4]};
                d = '{scale_den[k % 4], 1, 1, scale_den[k % 4]};
            end
            gfx_cmd_pkg::OP_ROT_L: begin
                m = '{cos_tab[k], -sin_tab[k], sin_tab[k], cos_tab[k]};
                d = '{`GFX_ROT_DIV, `GFX_ROT_DIV, `GFX_ROT_DIV, `GFX_ROT_DIV};
            end
            gfx_cmd_pkg::OP_ROT_R: begin
                m = '{cos_tab[k], sin_tab[k], -sin_tab[k], cos_tab[k]};
                d = '{`GFX_ROT_DIV, `GFX_ROT_DIV, `GFX_ROT_DIV, `GFX_ROT_DIV};
            end
            gfx_cmd_pkg::OP_REF_X: m[3] = -1;   // y flips
            gfx_cmd_pkg::OP_REF_Y: m[0] = -1;
            default: m = '{-1, 0, 0, -1};
        endcase
        sx = 0;
        sy = 0;
        for (int i = 0; i < n; i++) begin
            sx += int'(o.v[i].x);
            sy += int'(o.v[i].y);
        end
        cx = sx / n;   // truncates toward zero
        cy = sy / n;
        for (int i = 0; i < n; i++) begin
            dx = int'(o.v[i].x) - cx;
            dy = int'(o.v[i].y) - cy;
            r.v[i].x = 16'(dx * m[0] / d[0] + dy * m[1] / d[1] + cx);
            r.v[i].y = 16'(dx * m[2] / d[2] + dy * m[3] / d[3] + cy);
        end
        return r;
    endfunction

    task automatic run_cmd(input gfx_cmd_pkg::gfx_cmd_t c);
        @(negedge clk);
        while (busy)
            @(negedge clk);
        cmd    = c;
        cmd_go = 1'b1;
        @(negedge clk);
        cmd_go = 1'b0;
        while (!cmd_done)
            @(negedge clk);
    endtask

    task automatic create_obj(input gfx_obj_pkg::obj_kind_t kind, input logic [7:0] colour);
        gfx_cmd_pkg::gfx_cmd_t c;
        int exp_slot;
        c = '0;
        c.op     = gfx_cmd_pkg::OP_CREATE;
        c.kind   = kind;
        c.colour = colour;
        for (int i = 0; i < 4; i++) begin
            c.v[i].x = rand_coord();
            c.v[i].y = rand_coord();
        end
        exp_slot = -1;   // lowest free slot, none if full
        for (int i = `GFX_SLOTS - 1; i >= 0; i--) begin
            if (!model_occ[i])
                exp_slot = i;
        end
        run_cmd(c);
        assert (cmd_err == (exp_slot < 0))
            else abort_run($sformatf("ERR %0t: create cmd_err %0b", $time, cmd_err));
        if (exp_slot >= 0) begin
            assert (int'(new_slot) == exp_slot)
                else abort_run($sformatf("ERR %0t: create gave slot %0d, expected %0d",
                                         $time, new_slot, exp_slot));
            model_occ[exp_slot]        = 1'b1;
            model_obj[exp_slot]        = '0;
            model_obj[exp_slot].kind   = kind;
            model_obj[exp_slot].colour = colour;
            model_obj[exp_slot].v      = c.v;
        end
    endtask

    task automatic delete_obj(input int slot);
        gfx_cmd_pkg::gfx_cmd_t c;
        c = '0;
        c.op   = gfx_cmd_pkg::OP_DELETE;
        c.slot = 5'(slot);
        run_cmd(c);
        assert (cmd_err == !model_occ[slot])
            else abort_run($sformatf("ERR %0t: delete slot %0d cmd_err %0b", $time, slot, cmd_err));
        model_occ[slot] = 1'b0;
    endtask

    task automatic read_back(input int slot);
        gfx_cmd_pkg::gfx_cmd_t c;
        c = '0;
        c.op   = gfx_cmd_pkg::OP_LOADBACK;
        c.slot = 5'(slot);
        run_cmd(c);
        assert (cmd_err == !model_occ[slot])
            else abort_run($sformatf("ERR %0t: loadback slot %0d cmd_err %0b",
                                     $time, slot, cmd_err));
        if (model_occ[slot]) begin
            assert (rd_obj == model_obj[slot])
                else abort_run($sformatf("ERR %0t: slot %0d read %h, expected %h",
                                         $time, slot, rd_obj, model_obj[slot]));
        end
    endtask

    // geometry command, then a loadback to see the stored result
    task automatic transform(input gfx_cmd_pkg::gmt_op_t op, input logic [3:0] code,
                             input int slot);
        gfx_cmd_pkg::gfx_cmd_t c;
        c = '0;
        c.op     = op;
        c.code   = code;
        c.slot   = 5'(slot);
        c.v[0].x = rand_coord();
        c.v[0].y = rand_coord();
        run_cmd(c);
        assert (cmd_err == !model_occ[slot])
            else abort_run($sformatf("ERR %0t: op %s on slot %0d cmd_err %0b",
                                     $time, op.name(), slot, cmd_err));
        if (model_occ[slot])
            model_obj[slot] = expect_xform(model_obj[slot], c);
        read_back(slot);
    endtask

    task automatic stream_frame();
        int exp_q [$];
        int k;
        for (int i = 0; i < `GFX_SLOTS; i++) begin
            if (model_occ[i])
                exp_q.push_back(i);
        end
        k = 0;
        @(negedge clk);
        frame = 1'b1;
        @(negedge clk);
        frame = 1'b0;
        while (!disp_end) begin
            if (disp_vld) begin
                assert (k < exp_q.size())
                    else abort_run($sformatf("ERR %0t: extra object on display stream", $time));
                assert (disp_obj == model_obj[exp_q[k]])
                    else abort_run($sformatf("ERR %0t: stream object %0d is %h, expected %h",
                                             $time, k, disp_obj, model_obj[exp_q[k]]));
                k++;
            end
            @(negedge clk);
        end
        assert (k == exp_q.size())
            else abort_run($sformatf("ERR %0t: stream gave %0d objects, expected %0d",
                                     $time, k, exp_q.size()));
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_go    = 1'b0;
        frame     = 1'b0;
        model_occ = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        create_obj(gfx_obj_pkg::KIND_POINT, 8'h11);
        create_obj(gfx_obj_pkg::KIND_LINE, 8'h22);
        create_obj(gfx_obj_pkg::KIND_TRI, 8'h33);
        create_obj(gfx_obj_pkg::KIND_QUAD, 8'h44);
        for (int s = 0; s < 4; s++)
            read_back(s);

        // code is {pt, app_y, app_x}
        for (int xy = 1; xy < 4; xy++)
            transform(gfx_cmd_pkg::OP_TRANS_ALL, 4'(xy), 3);
        for (int pt = 0; pt < 4; pt++) begin
            for (int xy = 1; xy < 4; xy++)
                transform(gfx_cmd_pkg::OP_TRANS_ONE, 4'(pt * 4 + xy), 3);
        end
        transform(gfx_cmd_pkg::OP_TRANS_ONE, 4'hF, 1);   // point 3 of a line is unused

        for (int s = 2; s < 4; s++) begin
            for (int k = 0; k < 4; k++)
                transform(gfx_cmd_pkg::OP_SCALE, 4'(k), s);
        end
        for (int s = 1; s < 4; s++) begin
            transform(gfx_cmd_pkg::OP_REF_X, 4'h0, s);
            transform(gfx_cmd_pkg::OP_REF_Y, 4'h0, s);
            transform(gfx_cmd_pkg::OP_REF_XY, 4'h0, s);
        end

        for (int s = 2; s < 4; s++) begin
            transform(gfx_cmd_pkg::OP_ROT_L, 4'h4, s);
            transform(gfx_cmd_pkg::OP_ROT_R, 4'h4, s);
            transform(gfx_cmd_pkg::OP_ROT_L, 4'h1, s);
            transform(gfx_cmd_pkg::OP_ROT_R, 4'h1, s);
        end

        for (int i = 4; i < `GFX_SLOTS; i++)
            create_obj(gfx_obj_pkg::obj_kind_t'(i % 4), 8'(i * 29));
        create_obj(gfx_obj_pkg::KIND_LINE, 8'h55);   // table full
        delete_obj(10);
        read_back(10);
        create_obj(gfx_obj_pkg::KIND_TRI, 8'h66);    // lands in slot 10 again
        delete_obj(20);
        transform(gfx_cmd_pkg::OP_TRANS_ALL, 4'h3, 20);
        delete_obj(20);

        // loadbacks compete with the display fetcher for the memory
        fork
            stream_frame();
            for (int i = 0; i < 6; i++)
                read_back(i * 5);
        join
        fork
            stream_frame();
            for (int i = 0; i < 6; i++)
                read_back(i * 3 + 1);
        join

        repeat (2) @(negedge clk);
        if (gfx_engine_inst.assert_inst.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(negedge clk) begin
        if (gfx_engine_inst.assert_inst.fail_cnt != 0)
            abort_run("a protocol assertion on gfx_engine failed");
    end

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("timeout: the run did not finish within the watchdog limit");
    end

endmodule

// ==== gfx_engine.f ====
+incdir+verilog
verilog/gfx_obj_pkg.sv
verilog/gfx_cmd_pkg.sv
verilog/coeff_rom.sv
verilog/matrix_unit.sv
verilog/obj_slot_table.sv
verilog/obj_mem_arb.sv
verilog/display_fetch.sv
verilog/gfx_engine.sv
verif/gfx_engine_assert.sv
verif/gfx_engine_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := gfx_engine_tb
FILELIST  := gfx_engine.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM_ARGS  := +verilator+error+limit+100
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)
